// File: design/fixed_quant_pkg.sv
package fixed_quant_pkg;

  // One input lane as it arrives from the datapath.
  typedef logic signed [15:0] sample_t;

  // Magnitude of a sample. It is unsigned so that the magnitude of -32768 still fits.
  typedef logic [15:0] mag_t;

  // One output lane after the block shift.
  typedef logic signed [7:0] quant_t;

  // Right-shift amount applied to every lane of a block.
  typedef logic [3:0] shift_t;

  // Largest magnitude that a quantized lane may carry after the shift.
  localparam int QUANT_MAX = 127;

  // 32768 >> 9 is 64, so no block ever needs more than nine positions.
  localparam int MAX_SHIFT = 9;

  // Metadata that travels next to the quantized lanes of one block.
  typedef struct packed {
    shift_t shift;
    mag_t   max_abs;
  } quant_meta_t;

  // Absolute value of a sample.
  // The negation of 16'h8000 wraps to itself, which reads as 32768 once unsigned.
  function automatic mag_t abs_sample(sample_t s);
    return s[15] ? mag_t'(-s) : mag_t'(s);
  endfunction

endpackage

// File: design/skid_buffer.sv
`timescale 1ns/1ps

module skid_buffer #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     reset,
  input  payload_t in_data,
  input  logic     in_valid,
  output logic     in_ready,
  output payload_t out_data,
  output logic     out_valid,
  input  logic     out_ready
);

  // The skid entry catches the one beat that arrives while the output stalls.
  payload_t skid_data;
  logic     skid_valid;
  logic     in_fire;
  logic     out_free;

  // Ready only looks at the skid flop, so it never depends on out_ready.
  assign in_ready = !skid_valid;
  assign in_fire  = in_valid && in_ready;

  // The main register may load when it is empty or is being emptied this cycle.
  assign out_free = !out_valid || out_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid  <= 1'b0;
      skid_valid <= 1'b0;
    end else if (out_free) begin
      // A parked beat always goes first.
      // While it is parked, in_ready is low and nothing new can arrive.
      out_valid  <= skid_valid || in_fire;
      skid_valid <= 1'b0;
    end else if (in_fire) begin
      skid_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (out_free) begin
      out_data <= skid_valid ? skid_data : in_data;
    end
    // Park the incoming beat when the main register is stalled.
    if (!out_free && in_fire) begin
      skid_data <= in_data;
    end
  end

  // A stalled beat must stay at the output, unchanged, until it is taken.
  assert property (@(posedge clk) disable iff (reset)
    out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

// File: design/fixed_comparator_tree_layer.sv
`timescale 1ns/1ps

module fixed_comparator_tree_layer #(
  parameter int IN_SIZE = 2
) (
  input  fixed_quant_pkg::sample_t [IN_SIZE-1:0]       data_in,
  output fixed_quant_pkg::sample_t [(IN_SIZE+1)/2-1:0] data_out
);

  import fixed_quant_pkg::*;

  // Each output covers one pair of inputs.
  localparam int OUT_SIZE = (IN_SIZE + 1) / 2;

  for (genvar j = 0; j < OUT_SIZE; j++) begin : pair
    if (2 * j + 1 < IN_SIZE) begin : cmp
      // The upper lane wins only when it is strictly larger.
      // So a tie keeps the lower index.
      assign data_out[j] = (abs_sample(data_in[2*j+1]) > abs_sample(data_in[2*j])) ?
                           data_in[2*j+1] : data_in[2*j];
    end else begin : pass
      // An odd lane has no partner at this level and moves up unchanged.
      assign data_out[j] = data_in[2*j];
    end
  end

endmodule

// File: design/fixed_comparator_tree.sv
`timescale 1ns/1ps

module fixed_comparator_tree #(
  parameter int IN_SIZE = 8
) (
  input  logic                                  clk,
  input  logic                                  reset,
  input  fixed_quant_pkg::sample_t [IN_SIZE-1:0] data_in,
  input  logic                                  data_in_valid,
  output logic                                  data_in_ready,
  output fixed_quant_pkg::mag_t                 data_out,
  output logic                                  data_out_valid,
  input  logic                                  data_out_ready
);

  import fixed_quant_pkg::*;

  // One register stage per halving, so a single lane gives no stage at all.
  localparam int LEVELS = $clog2(IN_SIZE);

  // Stage boundaries.
  // Index 0 is the tree input and index LEVELS holds the single winner.
  for (genvar i = 0; i <= LEVELS; i++) begin : vars
    // Lane count at boundary i is IN_SIZE divided by 2**i, rounded up.
    localparam int LEVEL_SIZE = (IN_SIZE + (1 << i) - 1) >> i;

    sample_t [LEVEL_SIZE-1:0] data;
    logic                     valid;
    logic                     ready;
  end

  for (genvar i = 0; i < LEVELS; i++) begin : level
    localparam int LEVEL_SIZE = (IN_SIZE + (1 << i) - 1) >> i;
    localparam int NEXT_SIZE  = (LEVEL_SIZE + 1) / 2;

    // The slice carries exactly the lanes that survive this level.
    typedef sample_t [NEXT_SIZE-1:0] level_vec_t;

    level_vec_t cmp;

    fixed_comparator_tree_layer #(
      .IN_SIZE (LEVEL_SIZE)
    ) i_layer (
      .data_in  (vars[i].data),
      .data_out (cmp)
    );

    // Each level is closed by a register slice, which adds exactly one cycle.
    skid_buffer #(
      .payload_t (level_vec_t)
    ) i_slice (
      .clk       (clk),
      .reset     (reset),
      .in_data   (cmp),
      .in_valid  (vars[i].valid),
      .in_ready  (vars[i].ready),
      .out_data  (vars[i+1].data),
      .out_valid (vars[i+1].valid),
      .out_ready (vars[i+1].ready)
    );
  end

  // The block enters at boundary 0.
  assign vars[0].data  = data_in;
  assign vars[0].valid = data_in_valid;
  assign data_in_ready = vars[0].ready;

  // The winner still carries its sign.
  // The magnitude is taken only here, after the last stage.
  assign data_out           = abs_sample(vars[LEVELS].data[0]);
  assign data_out_valid     = vars[LEVELS].valid;
  assign vars[LEVELS].ready = data_out_ready;

endmodule

// File: design/block_dispatch.sv
`timescale 1ns/1ps

module block_dispatch #(
  parameter int IN_SIZE = 8
) (
  input  logic                                   clk,
  input  logic                                   reset,
  input  fixed_quant_pkg::sample_t [IN_SIZE-1:0] in_data,
  input  logic                                   in_valid,
  output logic                                   in_ready,
  output fixed_quant_pkg::sample_t [IN_SIZE-1:0] tree_data,
  output logic                                   tree_valid,
  input  logic                                   tree_ready,
  output fixed_quant_pkg::sample_t [IN_SIZE-1:0] store_data,
  output logic                                   store_valid,
  input  logic                                   store_ready
);

  import fixed_quant_pkg::*;

  // A set flag means that branch already holds its copy of the current block.
  logic tree_done;
  logic store_done;
  logic in_fire;

  // Both branches see the same lanes.
  assign tree_data  = in_data;
  assign store_data = in_data;

  // A branch is offered the block only until it has taken it once.
  assign tree_valid  = in_valid && !tree_done;
  assign store_valid = in_valid && !store_done;

  // The input retires when each branch has taken it or takes it now.
  assign in_ready = (tree_done || tree_ready) && (store_done || store_ready);
  assign in_fire  = in_valid && in_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      tree_done  <= 1'b0;
      store_done <= 1'b0;
    end else if (in_fire) begin
      // The next block starts with both branches pending again.
      tree_done  <= 1'b0;
      store_done <= 1'b0;
    end else begin
      if (tree_valid && tree_ready) begin
        tree_done <= 1'b1;
      end
      if (store_valid && store_ready) begin
        store_done <= 1'b1;
      end
    end
  end

  // A set flag refers to the block still held at the input.
  // The source must keep offering that very block until the other branch takes it.
  assert property (@(posedge clk) disable iff (reset)
    (tree_done || store_done) |-> in_valid && $stable(in_data));

endmodule

// File: design/vector_fifo.sv
`timescale 1ns/1ps

module vector_fifo #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 4
) (
  input  logic     clk,
  input  logic     reset,
  input  payload_t in_data,
  input  logic     in_valid,
  output logic     in_ready,
  output payload_t out_data,
  output logic     out_valid,
  input  logic     out_ready
);

  // A single entry still needs one pointer bit.
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t   mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             wr_en;
  logic             rd_en;

  // Both flags come straight from the counter.
  assign in_ready  = (count != CNT_W'(DEPTH));
  assign out_valid = (count != '0);
  assign wr_en     = in_valid && in_ready;
  assign rd_en     = out_valid && out_ready;

  // The head entry is shown without a read latency.
  // So a block written in one cycle is readable in the next.
  assign out_data = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // A write and a read together leave the fill level alone.
      if (wr_en && !rd_en) begin
        count <= count + 1'b1;
      end else if (rd_en && !wr_en) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= in_data;
    end
  end

  // A write hits the head slot only into an empty FIFO, so no unread entry is overwritten.
  assert property (@(posedge clk) disable iff (reset)
    wr_en && count != '0 |-> wr_ptr != rd_ptr);
  // A read with equal pointers comes from a full FIFO and never from an empty one.
  assert property (@(posedge clk) disable iff (reset)
    rd_en && wr_ptr == rd_ptr |-> count == CNT_W'(DEPTH));

endmodule

// File: design/block_scale_quantizer.sv
`timescale 1ns/1ps

module block_scale_quantizer #(
  parameter int IN_SIZE = 8
) (
  input  logic                                   clk,
  input  logic                                   reset,
  input  fixed_quant_pkg::mag_t                  mag_data,
  input  logic                                   mag_valid,
  output logic                                   mag_ready,
  input  fixed_quant_pkg::sample_t [IN_SIZE-1:0] vec_data,
  input  logic                                   vec_valid,
  output logic                                   vec_ready,
  output fixed_quant_pkg::quant_t [IN_SIZE-1:0]  out_data,
  output fixed_quant_pkg::quant_meta_t           out_meta,
  output logic                                   out_valid,
  input  logic                                   out_ready
);

  import fixed_quant_pkg::*;

  shift_t  shift;
  sample_t lane_shifted [IN_SIZE];
  logic    out_free;
  logic    fire;

  // The output register can load when empty or when its beat leaves now.
  assign out_free = !out_valid || out_ready;

  // Join of the two branches.
  // Each side is popped only together with the other, so blocks stay paired.
  assign fire      = mag_valid && vec_valid && out_free;
  assign mag_ready = vec_valid && out_free;
  assign vec_ready = mag_valid && out_free;

  // Walk down from the largest shift, and the last hit is the smallest fitting one.
  always_comb begin
    shift = shift_t'(MAX_SHIFT);
    for (int s = MAX_SHIFT; s >= 0; s--) begin
      if ((mag_data >> s) <= QUANT_MAX) begin
        shift = shift_t'(s);
      end
    end
  end

  // Arithmetic shift rounds toward minus infinity.
  // That is why a lane may end at -128.
  for (genvar i = 0; i < IN_SIZE; i++) begin : lane
    assign lane_shifted[i] = $signed(vec_data[i]) >>> shift;

    // This relies on the tree having reported the true block maximum.
    assert property (@(posedge clk) disable iff (reset)
      fire |-> ($signed(lane_shifted[i]) >= -128) &&
               ($signed(lane_shifted[i]) <= QUANT_MAX));
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else if (out_free) begin
      out_valid <= fire;
    end
  end

  always_ff @(posedge clk) begin
    if (fire) begin
      for (int i = 0; i < IN_SIZE; i++) begin
        out_data[i] <= quant_t'(lane_shifted[i]);   // keeps the low 8 bits
      end
      out_meta.shift   <= shift;
      out_meta.max_abs <= mag_data;
    end
  end

endmodule

// File: design/fixed_block_quantizer.sv
`timescale 1ns/1ps

module fixed_block_quantizer #(
  parameter int IN_SIZE   = 8,
  parameter int VEC_DEPTH = 5
) (
  input  logic                                   clk,
  input  logic                                   reset,
  input  fixed_quant_pkg::sample_t [IN_SIZE-1:0] in_data,
  input  logic                                   in_valid,
  output logic                                   in_ready,
  output fixed_quant_pkg::quant_t [IN_SIZE-1:0]  out_data,
  output fixed_quant_pkg::quant_meta_t           out_meta,
  output logic                                   out_valid,
  input  logic                                   out_ready
);

  import fixed_quant_pkg::*;

  // Payload of the vector store.
  typedef sample_t [IN_SIZE-1:0] sample_vec_t;

  sample_vec_t tree_data;
  logic        tree_valid;
  logic        tree_ready;
  sample_vec_t store_data;
  logic        store_valid;
  logic        store_ready;
  mag_t        mag_data;
  logic        mag_valid;
  logic        mag_ready;
  sample_vec_t vec_data;
  logic        vec_valid;
  logic        vec_ready;

  // Every accepted block is copied to the maximum search and to the lane store.
  block_dispatch #(
    .IN_SIZE (IN_SIZE)
  ) i_block_dispatch (
    .clk         (clk),
    .reset       (reset),
    .in_data     (in_data),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .tree_data   (tree_data),
    .tree_valid  (tree_valid),
    .tree_ready  (tree_ready),
    .store_data  (store_data),
    .store_valid (store_valid),
    .store_ready (store_ready)
  );

  fixed_comparator_tree #(
    .IN_SIZE (IN_SIZE)
  ) i_fixed_comparator_tree (
    .clk            (clk),
    .reset          (reset),
    .data_in        (tree_data),
    .data_in_valid  (tree_valid),
    .data_in_ready  (tree_ready),
    .data_out       (mag_data),
    .data_out_valid (mag_valid),
    .data_out_ready (mag_ready)
  );

  // The lanes wait here while the tree works.
  // VEC_DEPTH of at least LEVELS + 2 keeps one block per cycle.
  vector_fifo #(
    .payload_t (sample_vec_t),
    .DEPTH     (VEC_DEPTH)
  ) i_vector_fifo (
    .clk       (clk),
    .reset     (reset),
    .in_data   (store_data),
    .in_valid  (store_valid),
    .in_ready  (store_ready),
    .out_data  (vec_data),
    .out_valid (vec_valid),
    .out_ready (vec_ready)
  );

  block_scale_quantizer #(
    .IN_SIZE (IN_SIZE)
  ) i_block_scale_quantizer (
    .clk       (clk),
    .reset     (reset),
    .mag_data  (mag_data),
    .mag_valid (mag_valid),
    .mag_ready (mag_ready),
    .vec_data  (vec_data),
    .vec_valid (vec_valid),
    .vec_ready (vec_ready),
    .out_data  (out_data),
    .out_meta  (out_meta),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

endmodule

// File: dv/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD       = 8,
  parameter int RESET_CYCLES = 3
) (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // Reset drops with a nonblocking update, so the last reset edge still samples it high.
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

// File: dv/tb_fixed_block_quantizer.sv
`timescale 1ns/1ps

module tb_fixed_block_quantizer;

  import fixed_quant_pkg::*;

  localparam int IN_SIZE   = 8;
  localparam int VEC_DEPTH = 5;
  localparam int LEVELS    = $clog2(IN_SIZE);
  localparam int TIMEOUT   = 500;
  localparam int BLOCKS    = 50;

  typedef sample_t [IN_SIZE-1:0] sample_vec_t;
  typedef quant_t [IN_SIZE-1:0]  quant_vec_t;

  logic        clk;
  logic        reset;
  sample_vec_t in_data;
  logic        in_valid;
  logic        in_ready;
  quant_vec_t  out_data;
  quant_meta_t out_meta;
  logic        out_valid;
  logic        out_ready;

  // State shared by the driver, the output checker and the input monitor.
  logic [31:0] lfsr = 32'h5311;
  int          ready_mode = 1;   // 1 holds out_ready high, 2 draws it from the LFSR.
  int          cycle = 0;
  int          last_in_cycle = 0;
  int          data_errors = 0;
  int          meta_errors = 0;
  int          other_errors = 0;
  bit          aborted = 1'b0;
  bit          held_pending = 1'b0;
  sample_vec_t held_data;
  quant_vec_t  exp_data_q[$];
  quant_meta_t exp_meta_q[$];
  int          out_cycles[$];

  tb_clock_gen #(
    .PERIOD       (8),
    .RESET_CYCLES (3)
  ) i_clock_gen (
    .clk   (clk),
    .reset (reset)
  );

  fixed_block_quantizer #(
    .IN_SIZE   (IN_SIZE),
    .VEC_DEPTH (VEC_DEPTH)
  ) i_fixed_block_quantizer (
    .clk       (clk),
    .reset     (reset),
    .in_data   (in_data),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_data  (out_data),
    .out_meta  (out_meta),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  // Fibonacci LFSR with taps 32, 22, 2 and 1, stepped once per bit taken.
  function automatic logic next_bit();
    logic fb;
    fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], next_bit()};
    end
    return v;
  endfunction

  // A random width per block spreads the blocks over every shift value.
  function automatic sample_vec_t random_block();
    sample_vec_t blk;
    sample_t     lane;
    int          width;
    width = int'(rand_bits(4));
    for (int i = 0; i < IN_SIZE; i++) begin
      lane   = sample_t'(rand_bits(16));
      blk[i] = lane >>> (15 - width);
    end
    return blk;
  endfunction

  // The reference model finds the peak magnitude, then the smallest fitting shift.
  // Then it shifts each lane by that amount.
  function automatic void model(input sample_vec_t blk, output quant_vec_t q,
                                output quant_meta_t m);
    int peak;
    int v;
    int sh;
    peak = 0;
    for (int i = 0; i < IN_SIZE; i++) begin
      v = $signed(blk[i]);
      if (v < 0) begin
        v = -v;
      end
      if (v > peak) begin
        peak = v;
      end
    end
    sh = 0;
    while ((peak >> sh) > QUANT_MAX) begin
      sh++;
    end
    for (int i = 0; i < IN_SIZE; i++) begin
      v    = $signed(blk[i]);
      q[i] = quant_t'(v >>> sh);
    end
    m.shift   = shift_t'(sh);
    m.max_abs = mag_t'(peak);
  endfunction

  task automatic compare_data(input quant_vec_t expected, input quant_vec_t actual);
    if (actual !== expected) begin
      $display("ERR %0t out_data exp=%h act=%h", $time, expected, actual);
      data_errors++;
    end
  endtask

  task automatic compare_meta(input quant_meta_t expected, input quant_meta_t actual);
    if (actual !== expected) begin
      $display("ERR %0t out_meta exp=shift %0d max_abs %0d act=shift %0d max_abs %0d",
               $time, expected.shift, expected.max_abs, actual.shift, actual.max_abs);
      meta_errors++;
    end
  endtask

  task automatic note_timeout(input string what);
    $display("Timeout at %0t: %s", $time, what);
    other_errors++;
    aborted = 1'b1;
  endtask

  // Cycle count, read only on falling edges where it is stable.
  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  // A block offered while in_ready is low must still be offered, unchanged, on the next edge.
  always @(posedge clk) begin
    if (!reset) begin
      if (held_pending && (in_valid !== 1'b1 || in_data !== held_data)) begin
        $display("Input block changed at %0t while in_ready was low", $time);
        other_errors++;
      end
      held_pending = in_valid && !in_ready;
      held_data    = in_data;
    end
  end

  // On the output side, out_ready changes on the falling edge.
  // The beat seen here with out_ready high transfers on the next rising edge.
  initial begin
    out_ready = 1'b0;
    forever begin
      @(negedge clk);
      out_ready = (ready_mode == 2) ? next_bit() : 1'b1;
      if (!reset && out_valid && out_ready) begin
        take_output();
      end
    end
  end

  task automatic take_output();
    quant_vec_t  ed;
    quant_meta_t em;
    out_cycles.push_back(cycle);
    if (exp_data_q.size() == 0) begin
      $display("Output block at %0t arrived with no block outstanding", $time);
      other_errors++;
    end else begin
      ed = exp_data_q.pop_front();
      em = exp_meta_q.pop_front();
      compare_data(ed, out_data);
      compare_meta(em, out_meta);
    end
  endtask

  // Called on a falling edge. It returns on the falling edge after the transfer.
  task automatic drive_block(input sample_vec_t blk);
    int waited;
    waited   = 0;
    in_data  = blk;
    in_valid = 1'b1;
    while (!in_ready && !aborted) begin
      @(negedge clk);
      waited++;
      if (waited > TIMEOUT) begin
        note_timeout("in_ready stayed low while a block was offered");
      end
    end
    if (!aborted) begin
      last_in_cycle = cycle;
      @(negedge clk);
    end
  endtask

  task automatic send_block(input sample_vec_t blk);
    quant_vec_t  q;
    quant_meta_t m;
    model(blk, q, m);
    exp_data_q.push_back(q);
    exp_meta_q.push_back(m);
    drive_block(blk);
  endtask

  // Edge blocks check the metadata against values worked out by hand.
  task automatic send_edge(input sample_vec_t blk, input int shift, input int max_abs);
    quant_vec_t  q;
    quant_meta_t m;
    model(blk, q, m);
    m.shift   = shift_t'(shift);
    m.max_abs = mag_t'(max_abs);
    exp_data_q.push_back(q);
    exp_meta_q.push_back(m);
    drive_block(blk);
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_data_q.size() != 0 && !aborted) begin
      @(negedge clk);
      waited++;
      if (waited > TIMEOUT) begin
        note_timeout("expected output blocks never arrived");
      end
    end
  endtask

  // The mode changes on a rising edge, away from the falling edge where it is read.
  task automatic set_ready_mode(input int mode);
    @(posedge clk);
    ready_mode = mode;
    @(negedge clk);
  endtask

  task automatic test_reset();
    int waited;
    waited = 0;
    while (reset && !aborted) begin
      @(negedge clk);
      waited++;
      if (waited > TIMEOUT) begin
        note_timeout("reset was never released");
      end
    end
    if (out_valid !== 1'b0) begin
      $display("out_valid was high at %0t right after reset", $time);
      other_errors++;
    end
    // in_ready is due in the first cycle after reset.
    waited = 0;
    while (in_ready !== 1'b1 && !aborted) begin
      @(negedge clk);
      waited++;
      if (waited > 1) begin
        note_timeout("in_ready did not rise in the first cycle after reset");
      end
    end
  endtask

  task automatic test_edge_blocks();
    sample_vec_t blk;
    blk = '0;
    send_edge(blk, 0, 0);
    blk[5] = sample_t'(127);
    blk[1] = sample_t'(-127);
    blk[2] = sample_t'(40);
    send_edge(blk, 0, 127);
    blk[6] = sample_t'(128);
    blk[0] = sample_t'(-100);
    send_edge(blk, 1, 128);
    blk    = '0;
    blk[3] = sample_t'(-32768);
    blk[4] = sample_t'(1000);
    send_edge(blk, 9, 32768);
    // Equal magnitudes of opposite sign report the shared magnitude.
    blk    = '0;
    blk[2] = sample_t'(300);
    blk[5] = sample_t'(-300);
    send_edge(blk, 2, 300);
    in_valid = 1'b0;
    wait_drain();
  endtask

  task automatic test_latency();
    out_cycles.delete();
    send_block(random_block());
    in_valid = 1'b0;
    wait_drain();
    if (!aborted) begin
      if (out_cycles.size() != 1) begin
        $display("Expected one output block after a single input, saw %0d", out_cycles.size());
        other_errors++;
      end else if (out_cycles[0] - last_in_cycle != LEVELS + 1) begin
        $display("ERR %0t latency exp=%0d act=%0d", $time, LEVELS + 1,
                 out_cycles[0] - last_in_cycle);
        other_errors++;
      end
    end
  endtask

  task automatic test_burst();
    int first_in;
    first_in = 0;
    out_cycles.delete();
    for (int n = 0; n < BLOCKS; n++) begin
      send_block(random_block());
      if (n == 0) begin
        first_in = last_in_cycle;
      end
    end
    in_valid = 1'b0;
    wait_drain();
    if (!aborted && last_in_cycle - first_in != BLOCKS - 1) begin
      $display("The input did not accept one block per cycle during the burst");
      other_errors++;
    end
    if (!aborted && (out_cycles.size() != BLOCKS ||
                     out_cycles[BLOCKS-1] - out_cycles[0] != BLOCKS - 1)) begin
      $display("The output did not deliver one block per cycle during the burst");
      other_errors++;
    end
  endtask

  task automatic test_backpressure();
    sample_vec_t blocks [BLOCKS];
    // All blocks are drawn first, so only out_ready steps the LFSR afterwards.
    for (int n = 0; n < BLOCKS; n++) begin
      blocks[n] = random_block();
    end
    out_cycles.delete();
    set_ready_mode(2);
    for (int n = 0; n < BLOCKS; n++) begin
      send_block(blocks[n]);
    end
    in_valid = 1'b0;
    wait_drain();
    set_ready_mode(1);
    if (!aborted && out_cycles.size() != BLOCKS) begin
      $display("Back-pressure run delivered %0d blocks instead of %0d",
               out_cycles.size(), BLOCKS);
      other_errors++;
    end
  endtask

  initial begin
    in_data  = '0;
    in_valid = 1'b0;
    @(negedge clk);
    test_reset();
    test_edge_blocks();
    test_latency();
    test_burst();
    test_backpressure();
    $display("Summary: %0d data errors, %0d meta errors, %0d other errors",
             data_errors, meta_errors, other_errors);
    if (data_errors + meta_errors + other_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: build.f
design/fixed_quant_pkg.sv
design/skid_buffer.sv
design/fixed_comparator_tree_layer.sv
design/fixed_comparator_tree.sv
design/block_dispatch.sv
design/vector_fifo.sv
design/block_scale_quantizer.sv
design/fixed_block_quantizer.sv
dv/tb_clock_gen.sv
dv/tb_fixed_block_quantizer.sv

// File: run.sh
#!/bin/sh
# Compile with Verilator, run the testbench and look for the pass line.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f build.f \
  --top-module tb_fixed_block_quantizer -o sim_tb

# A failing run is decided below, so the exit code of the run itself is not fatal here.
out=$(./obj_dir/sim_tb 2>&1) || true
printf '%s\n' "$out"

# The script fails when the pass line is missing.
printf '%s\n' "$out" | grep -qF '*** PASSED ***'
